// ==== all.f ====
logic/cam_pkg.sv
logic/uart_pkg.sv
logic/pixel_capture.sv
logic/frame_buffer.sv
logic/frame_ctrl.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/cam_uart_top.sv
testbench/tb_clock.sv
testbench/tb_cam_uart.sv

// ==== logic/cam_pkg.sv ====
// ============================================================
// Camera side types and frame buffer sizing
// Pixel port is 4 bits wide and synchronous to clk
// Buffer holds FB_DEPTH bytes, later bytes of a frame are lost
// ============================================================
package cam_pkg;

    typedef logic [3:0] nibble_t;     // One pixel port sample
    typedef logic [7:0] pixel_t;      // Packed byte, first nibble high

    localparam int FB_DEPTH = 256;    // Buffer capacity in bytes

    typedef logic [7:0] fb_addr_t;    // Buffer address
    typedef logic [8:0] fb_count_t;   // Byte count, holds FB_DEPTH itself

    // Controller FSM
    typedef enum logic [2:0] {
        S_IDLE,       // Wait for a host command
        S_ARMED,      // Wait for the next start of frame
        S_CAPTURE,    // Store bytes until end of frame
        S_READ,       // Select a buffer read
        S_WAIT_ACK,   // Request raised, wait for transmitter ack
        S_WAIT_DROP   // Request dropped, wait for ack low
    } ctrl_state_t;

endpackage

// ==== logic/cam_uart_top.sv ====
// ============================================================
// Camera frame grab over UART, single clock domain
// Any host byte captures the next frame and sends it back
// Up to FB_DEPTH bytes per frame are returned
// ============================================================
`timescale 1ns/1ns

module cam_uart_top import cam_pkg::*; import uart_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_px_fv,
    input  logic    i_px_lv,
    input  nibble_t i_pxd,
    input  logic    i_uart_rx,
    output logic    o_uart_tx,
    output logic    o_sensor_trig
);

    pixel_t     px_byte;
    logic       px_byte_valid, px_sof, px_eof;
    logic       fb_cs, fb_we;
    fb_addr_t   fb_addr;
    pixel_t     fb_wdata, fb_rdata;
    logic       rx_valid;
    logic       tx_req, tx_ack;
    uart_byte_t tx_data;

    pixel_capture u_pixel_capture (
        .clk(clk), .rst(rst),
        .i_px_fv(i_px_fv), .i_px_lv(i_px_lv), .i_pxd(i_pxd),
        .o_byte(px_byte), .o_byte_valid(px_byte_valid),
        .o_sof(px_sof), .o_eof(px_eof)
    );

    frame_buffer u_frame_buffer (
        .clk(clk), .i_cs(fb_cs), .i_we(fb_we), .i_addr(fb_addr),
        .i_wdata(fb_wdata), .o_rdata(fb_rdata)
    );

    frame_ctrl u_frame_ctrl (
        .clk(clk), .rst(rst),
        .i_rx_valid(rx_valid), .i_sof(px_sof), .i_eof(px_eof),
        .i_byte_valid(px_byte_valid), .i_byte(px_byte),
        .i_fb_rdata(fb_rdata), .i_tx_ack(tx_ack),
        .o_fb_cs(fb_cs), .o_fb_we(fb_we), .o_fb_addr(fb_addr), .o_fb_wdata(fb_wdata),
        .o_tx_req(tx_req), .o_tx_data(tx_data), .o_sensor_trig(o_sensor_trig)
    );

    // Command content is not decoded
    uart_rx u_uart_rx (
        .clk(clk), .rst(rst), .i_rxd(i_uart_rx),
        .o_rx_valid(rx_valid), .o_rx_data()
    );

    uart_tx u_uart_tx (
        .clk(clk), .rst(rst), .i_tx_req(tx_req), .i_tx_data(tx_data),
        .o_tx_ack(tx_ack), .o_txd(o_uart_tx)
    );

endmodule

// ==== logic/frame_buffer.sv ====
// ============================================================
// Single port byte RAM, FB_DEPTH deep
// Read data is registered, valid the cycle after a read select
// Read data holds until the next read select
// ============================================================
`timescale 1ns/1ns

module frame_buffer import cam_pkg::*; (
    input  logic     clk,
    input  logic     i_cs,     // Select, read when i_we is low
    input  logic     i_we,
    input  fb_addr_t i_addr,
    input  pixel_t   i_wdata,
    output pixel_t   o_rdata
);

    pixel_t mem [FB_DEPTH];

    always_ff @(posedge clk) begin
        if (i_cs) begin
            if (i_we)
                mem[i_addr] <= i_wdata;
            else
                o_rdata <= mem[i_addr];        // One cycle read latency
        end
    end

    // Controller must qualify every write with a select
    a_we_needs_cs: assert property (@(posedge clk) i_we |-> i_cs)
        else $error("frame_buffer write without chip select");

endmodule

// ==== logic/frame_ctrl.sv ====
// ============================================================
// Command, capture and readout controller
// Any received byte is a command, ignored unless idle
// Capture waits for a start of frame after the command
// Readout uses a four-phase req/ack handshake to the UART
// ============================================================
`timescale 1ns/1ns

module frame_ctrl import cam_pkg::*; import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_rx_valid,     // Host command strobe
    input  logic       i_sof,
    input  logic       i_eof,
    input  logic       i_byte_valid,
    input  pixel_t     i_byte,
    input  pixel_t     i_fb_rdata,
    input  logic       i_tx_ack,
    output logic       o_fb_cs,
    output logic       o_fb_we,
    output fb_addr_t   o_fb_addr,
    output pixel_t     o_fb_wdata,
    output logic       o_tx_req,
    output uart_byte_t o_tx_data,
    output logic       o_sensor_trig
);

    ctrl_state_t state;
    fb_addr_t    addr;     // Write, then read pointer
    fb_count_t   count;    // Up during capture, down during readout

    // Buffer port, writes stop once full
    assign o_fb_we    = (state == S_CAPTURE) && i_byte_valid && (count < fb_count_t'(FB_DEPTH));
    assign o_fb_cs    = o_fb_we || (state == S_READ);
    assign o_fb_addr  = addr;
    assign o_fb_wdata = i_byte;
    assign o_tx_data  = i_fb_rdata;    // Held, no select during handshake

    // ============================================================
    // Controller FSM
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= S_IDLE;
            addr          <= '0;
            count         <= '0;
            o_tx_req      <= 1'b0;
            o_sensor_trig <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    addr  <= '0;
                    count <= '0;
                    if (i_rx_valid) begin
                        state         <= S_ARMED;
                        o_sensor_trig <= 1'b1;   // Kick the sensor
                    end
                end
                S_ARMED: if (i_sof) state <= S_CAPTURE;
                S_CAPTURE: begin
                    if (i_eof) begin
                        addr          <= '0;     // Read back from the start
                        o_sensor_trig <= 1'b0;
                        state         <= (count == '0) ? S_IDLE : S_READ;
                    end else begin
                        if (i_byte_valid)
                            o_sensor_trig <= 1'b0;   // First byte arrived
                        if (o_fb_we) begin
                            addr  <= addr + 1'b1;
                            count <= count + 1'b1;
                        end
                    end
                end
                S_READ: state <= S_WAIT_ACK;     // Read select this cycle
                S_WAIT_ACK: begin
                    if (!o_tx_req) begin
                        o_tx_req <= 1'b1;        // Read data valid now
                    end else if (i_tx_ack) begin
                        o_tx_req <= 1'b0;
                        state    <= S_WAIT_DROP;
                    end
                end
                S_WAIT_DROP: begin
                    if (!i_tx_ack) begin
                        count <= count - 1'b1;
                        addr  <= addr + 1'b1;
                        state <= (count == fb_count_t'(1)) ? S_IDLE : S_READ;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Handshake rules toward uart_tx
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        o_tx_req && !i_tx_ack |=> o_tx_req)
        else $error("tx req dropped before ack");
    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        o_tx_req && $past(o_tx_req) |-> $stable(o_tx_data))
        else $error("tx data changed while req high");

endmodule

// ==== logic/pixel_capture.sv ====
// ============================================================
// Packs nibble pairs into bytes and marks frame boundaries
// Pixel port must be synchronous to clk
// An odd nibble left at the end of a line is discarded
// Outputs are registered, one cycle after the sampling edge
// ============================================================
`timescale 1ns/1ns

module pixel_capture import cam_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_px_fv,       // Frame valid
    input  logic    i_px_lv,       // Line valid
    input  nibble_t i_pxd,
    output pixel_t  o_byte,
    output logic    o_byte_valid,  // One cycle strobe per byte
    output logic    o_sof,         // Rising frame valid
    output logic    o_eof          // Falling frame valid
);

    logic    fv_q;      // Frame valid, last sample
    logic    phase;     // High when the next nibble is the low half
    nibble_t hi_nib;    // First nibble of the pair

    // ============================================================
    // Nibble pairing
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            phase        <= 1'b0;
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;
            if (!i_px_lv) begin
                phase <= 1'b0;                 // Drops any odd trailing nibble
            end else if (!phase) begin
                phase <= 1'b1;
            end else begin
                phase        <= 1'b0;
                o_byte_valid <= 1'b1;          // Second nibble of the pair
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (i_px_lv && !phase)
            hi_nib <= i_pxd;
        if (i_px_lv && phase)
            o_byte <= {hi_nib, i_pxd};         // First nibble goes high
    end

    // ============================================================
    // Frame edges
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            fv_q  <= 1'b0;
            o_sof <= 1'b0;
            o_eof <= 1'b0;
        end else begin
            fv_q  <= i_px_fv;
            o_sof <= i_px_fv & ~fv_q;          // Rising edge
            o_eof <= ~i_px_fv & fv_q;          // Falling edge
        end
    end

endmodule

// ==== logic/uart_pkg.sv ====
// ============================================================
// UART timing and types, 8N1 only
// CLKS_PER_BIT is fixed here and shared by both directions
// ============================================================
package uart_pkg;

    localparam int CLKS_PER_BIT = 8;  // clk cycles per bit

    typedef logic [7:0] uart_byte_t;
    typedef logic [$clog2(CLKS_PER_BIT+1)-1:0] bit_cnt_t;  // Cycle count inside a bit

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_t;

endpackage

// ==== logic/uart_rx.sv ====
// ============================================================
// 8N1 UART receiver
// Line passes a two-flop synchronizer first
// Bits are sampled at mid-bit, LSB first
// Bytes with a bad start or stop bit are dropped silently
// ============================================================
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_rxd,
    output logic       o_rx_valid,     // One cycle strobe
    output uart_byte_t o_rx_data
);

    localparam bit_cnt_t HALF_BIT = bit_cnt_t'(CLKS_PER_BIT/2 - 1);
    localparam bit_cnt_t FULL_BIT = bit_cnt_t'(CLKS_PER_BIT - 1);

    rx_state_t  state;
    bit_cnt_t   cnt;        // Cycles inside the current bit
    logic [2:0] bit_idx;    // Data bit number
    logic       rxd_meta;
    logic       rxd_sync;

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta   <= 1'b1;   // Line idles high
            rxd_sync   <= 1'b1;
            state      <= RX_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            rxd_meta   <= i_rxd;
            rxd_sync   <= rxd_meta;
            o_rx_valid <= 1'b0;
            cnt        <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rxd_sync) state <= RX_START;   // Start edge
                end
                RX_START: if (cnt == HALF_BIT) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rxd_sync ? RX_IDLE : RX_DATA;  // Glitch check
                end
                RX_DATA: if (cnt == FULL_BIT) begin
                    cnt       <= '0;
                    bit_idx   <= bit_idx + 1'b1;
                    o_rx_data <= {rxd_sync, o_rx_data[7:1]};  // LSB first
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (cnt == FULL_BIT) begin
                    o_rx_valid <= rxd_sync;        // Framing error drops it
                    state      <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/uart_tx.sv ====
// ============================================================
// 8N1 UART transmitter, four-phase req/ack slave
// A byte is taken only when idle and with ack low
// Start bit begins on the cycle ack rises
// ============================================================
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_tx_req,
    input  uart_byte_t i_tx_data,
    output logic       o_tx_ack,
    output logic       o_txd
);

    localparam bit_cnt_t FULL_BIT = bit_cnt_t'(CLKS_PER_BIT - 1);

    tx_state_t  state;
    bit_cnt_t   cnt;
    logic [2:0] bit_idx;
    uart_byte_t shreg;      // Bits still to send, LSB next

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            o_tx_ack <= 1'b0;
            o_txd    <= 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
            if (o_tx_ack && !i_tx_req)
                o_tx_ack <= 1'b0;                 // Return to zero phase
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (i_tx_req && !o_tx_ack) begin
                        shreg    <= i_tx_data;
                        o_tx_ack <= 1'b1;
                        o_txd    <= 1'b0;         // Start bit
                        state    <= TX_START;
                    end
                end
                TX_START: if (cnt == FULL_BIT) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    o_txd   <= shreg[0];
                    state   <= TX_DATA;
                end
                TX_DATA: if (cnt == FULL_BIT) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    shreg   <= shreg >> 1;
                    if (bit_idx == 3'd7) begin
                        o_txd <= 1'b1;            // Stop bit
                        state <= TX_STOP;
                    end else begin
                        o_txd <= shreg[1];
                    end
                end
                TX_STOP: if (cnt == FULL_BIT) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Ack only answers a live request
    a_ack_on_req: assert property (@(posedge clk) disable iff (rst)
        $rose(o_tx_ack) |-> $past(i_tx_req))
        else $error("tx ack raised without req");

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds and runs the camera UART testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_cam_uart -o tb_cam_uart
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_cam_uart)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
echo "pass message not found"
exit 1

// ==== testbench/tb_cam_uart.sv ====
// ============================================================
// Testbench for cam_uart_top
// Host UART models run at CLKS_PER_BIT, line sampled at negedge
// Expected bytes come from the nibble stimulus, first nibble high
// Each wait on the DUT ends in a timeout that stops the run
// ============================================================
`timescale 1ns/1ns

module tb_cam_uart import cam_pkg::*; import uart_pkg::*; ();

    logic    clk, rst;
    logic    px_fv, px_lv, uart_rx_line, uart_tx_line, sensor_trig;
    nibble_t pxd;
    pixel_t  exp_q[$];         // Bytes the host should get back
    pixel_t  rx_q[$];          // Bytes decoded from o_uart_tx
    logic    quiet;            // Line idle and trigger low expected
    logic    trig_before, trig_after;
    int      errors, checks, test_errs;

    tb_clock u_clock (.o_clk(clk), .o_rst(rst));

    cam_uart_top cam_uart_top_i (
        .clk(clk), .rst(rst), .i_px_fv(px_fv), .i_px_lv(px_lv), .i_pxd(pxd),
        .i_uart_rx(uart_rx_line), .o_uart_tx(uart_tx_line), .o_sensor_trig(sensor_trig)
    );

    // ============================================================
    // Line checks
    // ============================================================
    a_reset_state: assert property (@(posedge clk) $past(rst) |-> uart_tx_line && !sensor_trig)
        else begin
            $display("FAIL %0t: tx line or trigger wrong during reset", $time);
            errors++;
        end
    a_quiet: assert property (@(posedge clk) disable iff (rst)
        quiet |-> uart_tx_line && !sensor_trig)
        else begin
            $display("FAIL %0t: tx line busy or trigger high in a quiet window", $time);
            errors++;
        end

    // Host side receiver, one byte per start bit
    initial begin : host_receive
        uart_byte_t b;
        forever begin
            @(negedge clk);
            if (!rst && uart_tx_line === 1'b0) begin
                repeat (CLKS_PER_BIT/2) @(negedge clk);       // Middle of start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    b[i] = uart_tx_line;                      // LSB first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                a_stop_bit: assert (uart_tx_line === 1'b1) else begin
                    $display("FAIL %0t: missing stop bit", $time);
                    errors++;
                end
                rx_q.push_back(b);
            end
        end
    end

    // ============================================================
    // Helpers
    // ============================================================
    task automatic step();
        @(posedge clk);
        #10;                                   // Drive point after the edge
    endtask

    task automatic stop_on_timeout(input string why);
        $display("%0t: timeout, %s", $time, why);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic host_send(input uart_byte_t b);
        uart_rx_line = 1'b0;                   // Start bit
        repeat (CLKS_PER_BIT) step();
        for (int i = 0; i < 8; i++) begin
            uart_rx_line = b[i];
            repeat (CLKS_PER_BIT) step();
        end
        uart_rx_line = 1'b1;                   // Stop bit, then idle
        repeat (CLKS_PER_BIT + 2) step();
    endtask

    task automatic wait_trigger();
        int n;
        for (n = 0; n < 4 * CLKS_PER_BIT && !sensor_trig; n++)
            step();
        if (!sensor_trig) stop_on_timeout("sensor trigger did not rise after a command");
    endtask

    task automatic wait_bytes(input int want);
        int n;
        for (n = 0; n < want * (10 * CLKS_PER_BIT + 20) + 500 && rx_q.size() < want; n++)
            step();
        if (rx_q.size() < want)
            stop_on_timeout($sformatf("got %0d of %0d bytes", rx_q.size(), want));
    endtask

    // Frame of lines with gaps, odd_mid adds a nibble to line 1
    task automatic send_frame(input int lines, input int nibs, input bit odd_mid, input bit keep);
        nibble_t hi;
        nibble_t nib;
        int      len;
        px_fv = 1'b1;
        repeat (4) step();
        for (int l = 0; l < lines; l++) begin
            len = nibs + ((odd_mid && l == 1) ? 1 : 0);
            if (l == 0) trig_before = sensor_trig;
            for (int j = 0; j < len; j++) begin
                nib   = nibble_t'($urandom);
                px_lv = 1'b1;
                pxd   = nib;
                if (j % 2 == 0)
                    hi = nib;
                else if (keep && exp_q.size() < FB_DEPTH)
                    exp_q.push_back({hi, nib});  // Later bytes are dropped by the DUT
                step();
            end
            px_lv = 1'b0;                       // Odd trailing nibble discarded
            pxd   = '0;
            repeat (3) step();
            if (l == 0) trig_after = sensor_trig;
        end
        px_fv = 1'b0;
        repeat (3) step();
    endtask

    task automatic compare_bytes();
        repeat (3 * 10 * CLKS_PER_BIT) step();  // Room for a surplus byte to show up
        checks++;
        a_count: assert (rx_q.size() == exp_q.size()) else begin
            $display("FAIL %0t: received %0d bytes, expected %0d", $time, rx_q.size(),
                     exp_q.size());
            errors++;
        end
        for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
            checks++;
            a_byte: assert (rx_q[i] == exp_q[i]) else begin
                $display("FAIL %0t: byte %0d is %h, expected %h", $time, i, rx_q[i], exp_q[i]);
                errors++;
            end
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    // Twice the readout time of nbytes with the line held idle
    task automatic quiet_window(input int nbytes);
        quiet = 1'b1;
        repeat (2 * nbytes * 10 * CLKS_PER_BIT) step();
        quiet = 1'b0;
        checks++;
        a_no_bytes: assert (rx_q.size() == 0) else begin
            $display("FAIL %0t: %0d unexpected bytes", $time, rx_q.size());
            errors++;
        end
        rx_q.delete();
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s %s", num, name, (errors == test_errs) ? "pass" : "fail");
        test_errs = errors;
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin : main
        int n;
        px_fv = 1'b0;
        px_lv = 1'b0;
        pxd = '0;
        uart_rx_line = 1'b1;
        quiet = 1'b0;
        errors = 0;
        checks = 0;
        test_errs = 0;
        void'($urandom(32'h559e));
        for (n = 0; n < 10 && rst !== 1'b0; n++)
            step();
        if (rst !== 1'b0) stop_on_timeout("reset never released");

        quiet = 1'b1;                          // No command, nothing comes back
        send_frame(2, 16, 1'b0, 1'b0);
        quiet_window(16);
        end_test(1, "frame without command");

        host_send(8'hA5);
        wait_trigger();
        send_frame(3, 10, 1'b1, 1'b1);         // 15 bytes, middle line odd
        checks += 2;
        a_trig_high: assert (trig_before) else begin
            $display("FAIL %0t: trigger low before first line", $time);
            errors++;
        end
        a_trig_fell: assert (!trig_after) else begin
            $display("FAIL %0t: trigger still high after first bytes", $time);
            errors++;
        end
        wait_bytes(exp_q.size());
        compare_bytes();
        end_test(2, "command, trigger and odd line frame");

        host_send(8'h01);
        wait_trigger();
        send_frame(0, 0, 1'b0, 1'b0);          // Frame valid only
        quiet_window(8);
        host_send(8'h02);
        wait_trigger();
        send_frame(2, 12, 1'b0, 1'b1);
        wait_bytes(exp_q.size());
        compare_bytes();
        end_test(3, "empty frame then capture");

        host_send(8'h03);
        wait_trigger();
        send_frame(5, 120, 1'b0, 1'b1);        // 300 bytes offered
        wait_bytes(FB_DEPTH);
        compare_bytes();
        end_test(4, "overflow capped at buffer depth");

        host_send(8'h04);
        wait_trigger();
        send_frame(2, 20, 1'b0, 1'b1);
        wait_bytes(1);
        host_send(8'h55);                      // Lands during readout
        wait_bytes(exp_q.size());
        compare_bytes();
        quiet = 1'b1;
        send_frame(2, 20, 1'b0, 1'b0);
        quiet_window(20);
        end_test(5, "command during readout ignored");

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== testbench/tb_clock.sv ====
// ============================================================
// Testbench clock and reset source
// 100 ns clock period, reset high for the first 3 rising edges
// Reset drops 10 ns after an edge, like all other stimulus
// ============================================================
`timescale 1ns/1ns

module tb_clock (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #50 o_clk = ~o_clk;   // 100 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (3) @(posedge o_clk);
        #10 o_rst = 1'b0;             // Synchronous release
    end

endmodule
